// File: design/ofdm_params_pkg.sv
// ################################################
// OFDM CP stage parameters
// ################################################

package ofdm_params_pkg;

  // One complex sample carries 16-bit I and 16-bit Q
  localparam int sample_w = 32;

  // CP lengths run up to 4095 samples
  localparam int cp_len_w = 12;

  // Symbol length field covers an FFT size of up to 4096
  localparam int sym_len_w = 13;

  // The sample counter must reach both the longest prefix and the longest symbol.
  // A CP is normally shorter than the FFT, but an odd setup could invert that
  localparam int cnt_w = (sym_len_w > cp_len_w) ? sym_len_w : cp_len_w;

  // The CP length list holds 16 entries
  localparam int list_depth_log2 = 4;

  // Number of entries in the list
  localparam int list_depth = 2 ** list_depth_log2;

  // Occupancy must reach the full depth, so it needs one bit more than a pointer
  localparam int occ_w = list_depth_log2 + 1;

  // CP length in force after reset and after a list clear.
  // Matches the short prefix of a 256-point symbol
  localparam logic [cp_len_w-1:0] default_cp_len = 16;

endpackage : ofdm_params_pkg

// File: design/ofdm_stream_pkg.sv
// ################################################
// OFDM CP stage stream types
// ################################################

package ofdm_stream_pkg;

  // One beat of the time-domain sample stream.
  // I sits in the upper half of the sample word and Q in the lower half,
  // which keeps the usual packing of complex samples on the bus
  typedef struct packed {
    // In-phase part
    logic [ofdm_params_pkg::sample_w/2-1:0] i;
    // Quadrature part
    logic [ofdm_params_pkg::sample_w/2-1:0] q;
    // Start-of-burst marker, carried unchanged from input to output
    logic                                   sob;
  } sample_beat_t;

  // One entry of the CP length list.
  // A length of zero means the symbol has no prefix at all
  typedef struct packed {
    logic [ofdm_params_pkg::cp_len_w-1:0] len;
  } cp_len_t;

endpackage : ofdm_stream_pkg

// File: design/cp_len_list.sv
// ################################################
// CP length list FIFO
// ################################################

`timescale 1ns/1ps

module cp_len_list (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              clear,
  input  ofdm_stream_pkg::cp_len_t          push_data,
  input  logic                              push_valid,
  output logic                              push_ready,
  output ofdm_stream_pkg::cp_len_t          pop_data,
  output logic                              pop_valid,
  input  logic                              pop_ready,
  output logic [ofdm_params_pkg::occ_w-1:0] occupied
);

  import ofdm_params_pkg::*;
  import ofdm_stream_pkg::*;

  // Storage for the queued lengths
  cp_len_t mem [list_depth];

  logic [list_depth_log2-1:0] wr_ptr;
  logic [list_depth_log2-1:0] rd_ptr;
  logic [occ_w-1:0]           count;

  logic full;
  logic empty;
  logic push_fire;
  logic pop_fire;

  assign full  = (count == occ_w'(list_depth));
  assign empty = (count == '0);

  // No writes are taken while the list is full or being cleared
  assign push_ready = ~full & ~clear;
  assign pop_valid  = ~empty;
  assign pop_data   = mem[rd_ptr];
  assign occupied   = count;

  assign push_fire = push_valid & push_ready;
  assign pop_fire  = pop_valid & pop_ready & ~clear;

  // Entries are written at the tail
  always_ff @(posedge clk) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers and count.
  // A push and a pop in the same cycle leave the count alone, and the
  // loopback in repeat mode relies on exactly that
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clear) begin
      // A clear drops every entry in one cycle
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_fire, pop_fire})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // A full list must refuse new entries, so the tail stays put until a pop
  // or a clear makes room
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (rst)
    (full && !pop_fire && !clear) |=> (wr_ptr == $past(wr_ptr)) && full
  );

  // occupancy never passes the list depth
  a_count_in_range: assert property (
    @(posedge clk) disable iff (rst)
    count <= occ_w'(list_depth)
  );

endmodule : cp_len_list

// File: design/cp_removal.sv
// ################################################
// Cyclic prefix removal engine
// ################################################

`timescale 1ns/1ps

module cp_removal (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  clear_list,
  input  logic                                  cp_repeat,
  input  logic [ofdm_params_pkg::sym_len_w-1:0] symbol_len,
  input  ofdm_stream_pkg::cp_len_t              pop_data,
  input  logic                                  pop_valid,
  output logic                                  cfg_pop,
  output logic                                  list_clear,
  output logic                                  loopback_sel,
  input  ofdm_stream_pkg::sample_beat_t         in_beat,
  input  logic                                  in_valid,
  output logic                                  in_ready,
  output ofdm_stream_pkg::sample_beat_t         out_beat,
  output logic                                  out_valid,
  output logic                                  out_last,
  input  logic                                  out_ready
);

  import ofdm_params_pkg::*;
  import ofdm_stream_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_config,
    st_prefix,
    st_symbol,
    st_clear
  } state_t;

  state_t state;

  // Length values in force for the current symbol
  cp_len_t              cp_len_reg;
  logic [sym_len_w-1:0] sym_len_reg;

  // Counts accepted samples from 1 within the prefix and within the symbol
  logic [cnt_w-1:0] cnt;

  // Set when the length in use came from the list head, which must then be popped
  logic cp_taken;

  // A clear request waits here until the engine is idle
  logic clear_hold;

  logic in_fire;
  logic prefix_done;
  logic symbol_done;

  assign in_fire     = in_valid & in_ready;
  assign prefix_done = (cnt >= cnt_w'(cp_len_reg.len));
  assign symbol_done = (cnt >= cnt_w'(sym_len_reg));

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      cp_len_reg <= '{len: default_cp_len};
      cnt        <= cnt_w'(1);
      cp_taken   <= 1'b0;
      clear_hold <= 1'b0;
    end else begin
      // Hold a clear pulse until the clear cycle has run.
      // A pulse landing in the clear cycle itself is kept for the next one
      if (state == st_clear) begin
        clear_hold <= clear_list;
      end else if (clear_list) begin
        clear_hold <= 1'b1;
      end

      unique case (state)
        st_idle: begin
          cnt <= cnt_w'(1);
          if (clear_hold) begin
            state <= st_clear;
          end else if (in_valid) begin
            // Take the list head only when there is one.
            // With an empty list the previous length stays in force
            if (pop_valid) begin
              cp_len_reg <= pop_data;
            end
            cp_taken    <= pop_valid;
            sym_len_reg <= symbol_len;
            state       <= st_config;
          end
        end

        st_config: begin
          // Skip phases whose length is zero
          if (cp_len_reg.len != '0) begin
            state <= st_prefix;
          end else if (sym_len_reg != '0) begin
            state <= st_symbol;
          end else begin
            state <= st_idle;
          end
        end

        st_prefix: begin
          if (in_fire) begin
            cnt <= cnt + 1'b1;
            if (prefix_done) begin
              cnt   <= cnt_w'(1);
              state <= (sym_len_reg != '0) ? st_symbol : st_idle;
            end
          end
        end

        st_symbol: begin
          if (in_fire) begin
            cnt <= cnt + 1'b1;
            if (symbol_done) begin
              cnt   <= cnt_w'(1);
              state <= st_idle;
            end
          end
        end

        st_clear: begin
          // The list empties this cycle and the default length comes back
          cp_len_reg <= '{len: default_cp_len};
          state      <= st_idle;
        end

        default: state <= st_idle;
      endcase
    end
  end

  // Pop the head that was latched in idle, and in repeat mode send it
  // back to the tail of the list in the same cycle
  assign cfg_pop      = (state == st_config) & cp_taken;
  assign loopback_sel = (state == st_config) & cp_repeat;
  assign list_clear   = (state == st_clear);

  // Prefix samples are swallowed at full rate.
  // Symbol samples pass straight through with no register in the path
  assign out_beat  = in_beat;
  assign out_valid = (state == st_symbol) & in_valid;
  assign out_last  = (state == st_symbol) & symbol_done;
  assign in_ready  = (state == st_prefix) | ((state == st_symbol) & out_ready);

  // Output beats only appear inside a symbol and never past its end
  a_out_in_symbol: assert property (
    @(posedge clk) disable iff (rst)
    out_valid |-> (state == st_symbol) && (cnt != '0) && (cnt <= cnt_w'(sym_len_reg))
  );

  // The engine pops only a list head that is still there and never while the list clears
  a_pop_clear_apart: assert property (
    @(posedge clk) disable iff (rst)
    cfg_pop |-> pop_valid && !list_clear
  );

endmodule : cp_removal

// File: design/ofdm_cp_removal_top.sv
// ################################################
// OFDM CP removal top
// ################################################

`timescale 1ns/1ps

module ofdm_cp_removal_top (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  clear_list,
  input  logic                                  cp_repeat,
  input  logic [ofdm_params_pkg::sym_len_w-1:0] symbol_len,
  input  ofdm_stream_pkg::cp_len_t              cp_len_data,
  input  logic                                  cp_len_valid,
  output logic                                  cp_len_ready,
  output logic [ofdm_params_pkg::occ_w-1:0]     occupied,
  input  ofdm_stream_pkg::sample_beat_t         in_beat,
  input  logic                                  in_valid,
  output logic                                  in_ready,
  output ofdm_stream_pkg::sample_beat_t         out_beat,
  output logic                                  out_valid,
  output logic                                  out_last,
  input  logic                                  out_ready
);

  import ofdm_params_pkg::*;
  import ofdm_stream_pkg::*;

  // List push side after the loopback multiplexer
  cp_len_t push_data;
  logic    push_valid;
  logic    push_ready;

  // List pop side, read by the engine
  cp_len_t pop_data;
  logic    pop_valid;

  logic cfg_pop;
  logic list_clear;
  logic loopback_sel;

  // In the config cycle of repeat mode the popped head feeds the list tail.
  // Otherwise the external stream owns the push side
  assign push_data  = loopback_sel ? pop_data : cp_len_data;
  assign push_valid = loopback_sel ? (cfg_pop & pop_valid) : (cp_len_valid & ~list_clear);

  // Software sees a stall during the loopback and the clear cycles
  assign cp_len_ready = push_ready & ~loopback_sel & ~list_clear;

  cp_len_list u_list (
    .clk        (clk),
    .rst        (rst),
    .clear      (list_clear),
    .push_data  (push_data),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .pop_data   (pop_data),
    .pop_valid  (pop_valid),
    .pop_ready  (cfg_pop),
    .occupied   (occupied)
  );

  cp_removal u_engine (
    .clk          (clk),
    .rst          (rst),
    .clear_list   (clear_list),
    .cp_repeat    (cp_repeat),
    .symbol_len   (symbol_len),
    .pop_data     (pop_data),
    .pop_valid    (pop_valid),
    .cfg_pop      (cfg_pop),
    .list_clear   (list_clear),
    .loopback_sel (loopback_sel),
    .in_beat      (in_beat),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .out_beat     (out_beat),
    .out_valid    (out_valid),
    .out_last     (out_last),
    .out_ready    (out_ready)
  );

  // A looped-back pop keeps the list size as long as the list had room
  a_loopback_keeps_count: assert property (
    @(posedge clk) disable iff (rst)
    (cfg_pop && loopback_sel && occupied != occ_w'(list_depth))
      |=> occupied == $past(occupied)
  );

endmodule : ofdm_cp_removal_top

// File: sim/tb_ofdm_cp_removal.sv
// ################################################
// CP removal testbench
// ################################################

`timescale 1ns/1ps

module tb_ofdm_cp_removal;

  import ofdm_params_pkg::*;
  import ofdm_stream_pkg::*;

  logic                 clk;
  logic                 rst;
  logic                 clear_list;
  logic                 cp_repeat;
  logic [sym_len_w-1:0] symbol_len;
  cp_len_t              cp_len_data;
  logic                 cp_len_valid;
  logic                 cp_len_ready;
  logic [occ_w-1:0]     occupied;
  sample_beat_t         in_beat;
  logic                 in_valid;
  logic                 in_ready;
  sample_beat_t         out_beat;
  logic                 out_valid;
  logic                 out_last;
  logic                 out_ready;

  // Command stream and expected beats from the vector file.
  // An expected entry packs i, q, sob and last in that order
  byte         ops[$];
  int          args[$];
  logic [33:0] exp_q[$];

  int seed;
  int counter;
  int total_samples;
  int limit_cycles;
  bit bp_on;

  ofdm_cp_removal_top ofdm_cp_removal_top_inst (.*);

  always #10 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      fail_run("A DUT output did not match the vector file");
    end
  endtask

  // Reads the whole file up front so the watchdog knows the run length
  task automatic load_vectors();
    int    fd;
    int    code;
    int    arg;
    int    ei;
    int    eq;
    int    es;
    int    el;
    string tok;
    string line;
    fd = $fopen("sim/cp_removal_vectors.txt", "r");
    if (fd == 0) begin
      fail_run("The vector file could not be opened");
    end
    while (!$feof(fd)) begin
      tok = "";
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        break;
      end
      if (tok == "#") begin
        code = $fgets(line, fd);
      end else if (tok == "E") begin
        code = $fscanf(fd, "%h %h %h %h", ei, eq, es, el);
        exp_q.push_back({ei[15:0], eq[15:0], es[0], el[0]});
      end else begin
        code = $fscanf(fd, "%d", arg);
        ops.push_back(tok.getc(0));
        args.push_back(arg);
        if (tok == "S") begin
          total_samples += arg;
        end
      end
    end
    $fclose(fd);
  endtask

  // Input samples follow a running counter so that each output is predictable
  task automatic send_samples(input int n);
    int k;
    bit done;
    k = 0;
    while (k < n) begin
      @(posedge clk);
      if (bp_on && (($random(seed) & 3) == 0)) begin
        in_valid <= 1'b0;
      end else begin
        in_valid     <= 1'b1;
        in_beat.i    <= counter[15:0];
        in_beat.q    <= counter[15:0] + 16'h1000;
        in_beat.sob  <= (k == 0);
        done = 1'b0;
        // The handshake is judged at the falling edge, where all levels are settled
        while (!done) begin
          @(negedge clk);
          if (in_ready) begin
            done = 1'b1;
          end else begin
            @(posedge clk);
          end
        end
        counter++;
        k++;
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic push_cp(input int len);
    bit done;
    @(posedge clk);
    cp_len_data  <= '{len: len[cp_len_w-1:0]};
    cp_len_valid <= 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (cp_len_ready) begin
        done = 1'b1;
      end else begin
        @(posedge clk);
      end
    end
    @(posedge clk);
    cp_len_valid <= 1'b0;
  endtask

  task automatic run_command(input byte op, input int arg);
    case (op)
      "L": begin
        @(posedge clk);
        symbol_len <= arg[sym_len_w-1:0];
      end
      "R": begin
        @(posedge clk);
        cp_repeat <= arg[0];
      end
      "P": push_cp(arg);
      "C": begin
        // The latched request reaches the clear state two edges after the pulse
        @(posedge clk);
        clear_list <= 1'b1;
        @(posedge clk);
        clear_list <= 1'b0;
        repeat (2) @(posedge clk);
      end
      "O": begin
        @(negedge clk);
        check_value("occupied", 32'(occupied), 32'(arg));
      end
      "B": begin
        @(negedge clk);
        bp_on = arg[0];
      end
      "S": send_samples(arg);
      default: fail_run("The vector file holds an unknown command");
    endcase
  endtask

  // Random back-pressure on the output side when enabled
  always @(posedge clk) begin
    if (bp_on) begin
      out_ready <= (($random(seed) & 3) != 0);
    end else begin
      out_ready <= 1'b1;
    end
  end

  // Every transferred output beat is compared with the next expected line
  always @(negedge clk) begin
    logic [33:0] e;
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        fail_run("An output beat arrived with no expected beat left");
      end else begin
        e = exp_q.pop_front();
        check_value("out_beat.i", 32'(out_beat.i), 32'(e[33:18]));
        check_value("out_beat.q", 32'(out_beat.q), 32'(e[17:2]));
        check_value("out_beat.sob", 32'(out_beat.sob), 32'(e[1]));
        check_value("out_last", 32'(out_last), 32'(e[0]));
      end
    end
  end

  // Run length scales with the number of samples in the vector file
  initial begin
    @(negedge rst);
    repeat (limit_cycles) @(posedge clk);
    fail_run("Timeout: the DUT stopped making progress");
  end

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    clear_list    = 1'b0;
    cp_repeat     = 1'b0;
    symbol_len    = '0;
    cp_len_data   = '0;
    cp_len_valid  = 1'b0;
    in_beat       = '0;
    in_valid      = 1'b0;
    out_ready     = 1'b1;
    seed          = 79;
    counter       = 0;
    total_samples = 0;
    bp_on         = 1'b0;
    load_vectors();
    limit_cycles = total_samples * 8 + 2000;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int n = 0; n < ops.size(); n++) begin
      run_command(ops[n], args[n]);
    end
    repeat (4) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      fail_run("Some expected output beats were never produced");
    end
  end

endmodule : tb_ofdm_cp_removal

// File: sim/cp_removal_vectors.txt
# Commands take one decimal argument: L sym_len, R repeat, P cp_len, C 1, O occupied, B bp, S count
# E i q sob last gives one expected output beat in hex
L 2
O 0
S 36
E 0010 1010 0 0
E 0011 1011 0 1
E 0022 1022 0 0
E 0023 1023 0 1
P 8
P 32
P 0
O 3
S 10
E 002c 102c 0 0
E 002d 102d 0 1
O 2
S 34
E 004e 104e 0 0
E 004f 104f 0 1
S 4
E 0050 1050 1 0
E 0051 1051 0 1
E 0052 1052 0 0
E 0053 1053 0 1
O 0
L 1
R 1
P 4
P 12
O 2
S 18
E 0058 1058 0 1
E 0065 1065 0 1
O 2
S 18
E 006a 106a 0 1
E 0077 1077 0 1
S 18
E 007c 107c 0 1
E 0089 1089 0 1
O 2
R 0
C 1
O 0
L 2
S 18
E 009a 109a 0 0
E 009b 109b 0 1
B 1
S 36
E 00ac 10ac 0 0
E 00ad 10ad 0 1
E 00be 10be 0 0
E 00bf 10bf 0 1
B 0

// File: src.f
design/ofdm_params_pkg.sv
design/ofdm_stream_pkg.sv
design/cp_len_list.sv
design/cp_removal.sv
design/ofdm_cp_removal_top.sv
sim/tb_ofdm_cp_removal.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the CP removal testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv \
  --top-module tb_ofdm_cp_removal \
  -f src.f \
  -Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_bin)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q '\*\*\* TEST PASSED \*\*\*'; then
  exit 0
fi

echo "Pass message not found"
exit 1
